// File: hw/clk_ratio_pkg.sv
// Divider ratio sizing and select codes used by scoped name across the enable controller RTL
package clk_ratio_pkg;

  // ------------------------------
  // Divider sizing
  // ------------------------------

  // Six ratios from divide by 1 up to divide by 32
  localparam integer N_RATIOS = 6;

  // Counter width is log2 of the largest ratio
  localparam integer CNT_W = 5;

  // Three bit select code per domain
  localparam integer SEL_W = 3;

  // Strobe bit that marks the ratio-32 boundary
  localparam integer BOUNDARY_BIT = N_RATIOS - 1;

  // ------------------------------
  // Types
  // ------------------------------

  // Free-running divider count
  typedef logic [CNT_W-1:0] div_cnt_t;

  // Code k selects divide by 2^k
  // Codes 6 and 7 fall back to divide by 32
  typedef logic [SEL_W-1:0] ratio_sel_t;

  // One strobe bit per ratio, bit k is the ratio-2^k strobe
  typedef logic [N_RATIOS-1:0] strobe_vec_t;

  // ------------------------------
  // Select constants
  // ------------------------------

  // Divide by 1 out of reset
  localparam ratio_sel_t SEL_RESET = 3'd0;

  // Highest code with its own ratio
  localparam ratio_sel_t SEL_MAX = 3'd5;

endpackage

// File: hw/clk_domain_pkg.sv
// Peripheral domain count and index codes used by scoped name in the config block and mux
package clk_domain_pkg;

  // ------------------------------
  // Domain sizing
  // ------------------------------

  // timer0, timer1, uart0, uart1 and watchdog
  localparam integer N_DOMAINS = 5;

  // Width of a domain index on the config port
  localparam integer DOM_ID_W = 3;

  // ------------------------------
  // Types
  // ------------------------------

  // Domain index, values 5 to 7 name no domain
  typedef logic [DOM_ID_W-1:0] domain_id_t;

  // One bit per peripheral domain
  typedef logic [N_DOMAINS-1:0] domain_vec_t;

  // ------------------------------
  // Domain indices
  // ------------------------------

  localparam domain_id_t DOM_TIMER0 = 3'd0;
  localparam domain_id_t DOM_TIMER1 = 3'd1;
  localparam domain_id_t DOM_UART0  = 3'd2;
  localparam domain_id_t DOM_UART1  = 3'd3;

  // Last valid index
  localparam domain_id_t DOM_WDOG   = 3'd4;

endpackage

// File: hw/ratio_strobe_gen.sv
// Free-running divider that gives the config block and the enable mux one strobe per ratio
`timescale 1ns/1ps

module ratio_strobe_gen (
  input  logic                       master_clk,
  input  logic                       rst,
  output clk_ratio_pkg::strobe_vec_t strobes
);

  // ------------------------------
  // Divider counter
  // ------------------------------

  clk_ratio_pkg::div_cnt_t div_cnt;

  // Wraps every 32 cycles so every ratio shares one phase
  always_ff @(posedge master_clk) begin
    if (rst) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // ------------------------------
  // Strobe decode
  // ------------------------------

  // Divide by 1 never skips a cycle
  assign strobes[0] = 1'b1;

  // Ratio 2^k fires while the low k counter bits are all ones.
  // At count 31 every strobe is high together, which is the
  // boundary the config block waits for.
  genvar k;
  generate
    for (k = 1; k < clk_ratio_pkg::N_RATIOS; k++) begin : g_strobe
      assign strobes[k] = &div_cnt[k-1:0];
    end
  endgenerate

endmodule

// File: hw/domain_config.sv
// Config write port that holds one select and gate change and applies it on the ratio-32 boundary
`timescale 1ns/1ps

module domain_config (
  input  logic                        master_clk,
  input  logic                        rst,

  // Write port
  input  logic                        cfg_valid,
  output logic                        cfg_ready,
  input  clk_domain_pkg::domain_id_t  cfg_domain,
  input  clk_ratio_pkg::ratio_sel_t   cfg_select,
  input  logic                        cfg_gate,

  // Divider strobes, only the boundary bit is used here
  input  clk_ratio_pkg::strobe_vec_t  strobes,

  // Active per-domain settings
  output clk_ratio_pkg::ratio_sel_t   dom_select [clk_domain_pkg::N_DOMAINS],
  output clk_domain_pkg::domain_vec_t dom_gate
);

  typedef enum logic {
    IDLE,
    PENDING
  } cfg_state_t;

  cfg_state_t                 state;
  logic                       cfg_accept;
  logic                       apply;
  clk_domain_pkg::domain_id_t pend_domain;
  clk_ratio_pkg::ratio_sel_t  pend_select;
  logic                       pend_gate;

  // ------------------------------
  // Handshake and FSM
  // ------------------------------

  // Only one change in flight at a time
  assign cfg_ready  = (state == IDLE);
  assign cfg_accept = cfg_valid && cfg_ready;

  // Change lands where all enables line up
  assign apply = (state == PENDING) && strobes[clk_ratio_pkg::BOUNDARY_BIT];

  always_ff @(posedge master_clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (cfg_accept) state <= PENDING;
        PENDING: if (apply) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Pending write, captured on the accepting edge
  always_ff @(posedge master_clk) begin
    if (cfg_accept) begin
      pend_domain <= cfg_domain;
      pend_select <= cfg_select;
      pend_gate   <= cfg_gate;
    end
  end

  // ------------------------------
  // Active settings
  // ------------------------------

  // An index past the watchdog matches no domain and is dropped
  always_ff @(posedge master_clk) begin
    if (rst) begin
      for (int d = 0; d < clk_domain_pkg::N_DOMAINS; d++) begin
        dom_select[d] <= clk_ratio_pkg::SEL_RESET;
      end
      dom_gate <= '0;
    end else if (apply) begin
      for (int d = 0; d < clk_domain_pkg::N_DOMAINS; d++) begin
        if (pend_domain == clk_domain_pkg::domain_id_t'(d)) begin
          dom_select[d] <= pend_select;
          dom_gate[d]   <= pend_gate;
        end
      end
    end
  end

endmodule

// File: hw/domain_enable_mux.sv
// Per-domain strobe select and gating into the registered free and gated enable outputs
`timescale 1ns/1ps

module domain_enable_mux (
  input  logic                        master_clk,
  input  logic                        rst,
  input  clk_ratio_pkg::strobe_vec_t  strobes,
  input  clk_ratio_pkg::ratio_sel_t   dom_select [clk_domain_pkg::N_DOMAINS],
  input  clk_domain_pkg::domain_vec_t dom_gate,
  output clk_domain_pkg::domain_vec_t free_en,
  output clk_domain_pkg::domain_vec_t gated_en
);

  clk_domain_pkg::domain_vec_t pick;

  // ------------------------------
  // Strobe select
  // ------------------------------

  always_comb begin
    clk_ratio_pkg::ratio_sel_t eff_sel;

    pick = '0;
    for (int d = 0; d < clk_domain_pkg::N_DOMAINS; d++) begin
      // Codes above the last ratio run at divide by 32
      if (dom_select[d] > clk_ratio_pkg::SEL_MAX) begin
        eff_sel = clk_ratio_pkg::SEL_MAX;
      end else begin
        eff_sel = dom_select[d];
      end
      pick[d] = strobes[eff_sel];
    end
  end

  // ------------------------------
  // Output registers
  // ------------------------------

  // Both enables come from the same selected strobe.
  // Gate only masks the second one, so the free enable
  // keeps pulsing for anything that needs a steady tick.
  always_ff @(posedge master_clk) begin
    if (rst) begin
      free_en  <= '0;
      gated_en <= '0;
    end else begin
      free_en  <= pick;
      gated_en <= pick & ~dom_gate;
    end
  end

endmodule

// File: hw/periph_clk_enable_ctrl.sv
// Top of the peripheral clock-enable controller that joins the divider, config block and mux
`timescale 1ns/1ps

module periph_clk_enable_ctrl (
  input  logic                        master_clk,
  input  logic                        rst,

  // Config write port
  input  logic                        cfg_valid,
  output logic                        cfg_ready,
  input  clk_domain_pkg::domain_id_t  cfg_domain,
  input  clk_ratio_pkg::ratio_sel_t   cfg_select,
  input  logic                        cfg_gate,

  // Per-domain enables
  output clk_domain_pkg::domain_vec_t free_en,
  output clk_domain_pkg::domain_vec_t gated_en
);

  clk_ratio_pkg::strobe_vec_t  strobes;
  clk_ratio_pkg::ratio_sel_t   dom_select [clk_domain_pkg::N_DOMAINS];
  clk_domain_pkg::domain_vec_t dom_gate;

  // ------------------------------
  // Ratio strobes
  // ------------------------------

  ratio_strobe_gen u_strobe_gen (
    .master_clk (master_clk),
    .rst        (rst),
    .strobes    (strobes)
  );

  // Select and gate registers
  domain_config u_domain_config (
    .master_clk (master_clk),
    .rst        (rst),
    .cfg_valid  (cfg_valid),
    .cfg_ready  (cfg_ready),
    .cfg_domain (cfg_domain),
    .cfg_select (cfg_select),
    .cfg_gate   (cfg_gate),
    .strobes    (strobes),
    .dom_select (dom_select),
    .dom_gate   (dom_gate)
  );

  // Enables
  domain_enable_mux u_enable_mux (
    .master_clk (master_clk),
    .rst        (rst),
    .strobes    (strobes),
    .dom_select (dom_select),
    .dom_gate   (dom_gate),
    .free_en    (free_en),
    .gated_en   (gated_en)
  );

endmodule

// File: dv/periph_clk_enable_ctrl_tb.sv
// Directed testbench for the peripheral clock-enable controller, built from verilog.f by the Makefile
`timescale 1ns/1ps

module periph_clk_enable_ctrl_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;
  localparam int STALL_LIMIT  = 40;
  localparam int GATE_WATCH   = 64;
  localparam int ALIGN_WATCH  = 128;

  // Worst case per write is a short idle wait, the accept edge and up to 32 cycles to apply
  localparam int WRITE_CYCLES = 40;

  // Per-test worst case in cycles
  // 162 and 130 bound the 4 and 3 pulse measurements at ratio 32
  localparam int TOTAL_CYCLES = (RESET_CYCLES + 40)
                              + (WRITE_CYCLES + 8 * (WRITE_CYCLES + 162 + 130))
                              + 2 * (WRITE_CYCLES + GATE_WATCH)
                              + (WRITE_CYCLES + 32 + 2 * STALL_LIMIT + 162)
                              + (5 * WRITE_CYCLES + ALIGN_WATCH)
                              + (3 * WRITE_CYCLES + 5 * 130 + GATE_WATCH);
  localparam int WATCHDOG_NS  = 2 * TOTAL_CYCLES * CLK_PERIOD;

  logic                        master_clk;
  logic                        rst;
  logic                        cfg_valid;
  logic                        cfg_ready;
  clk_domain_pkg::domain_id_t  cfg_domain;
  clk_ratio_pkg::ratio_sel_t   cfg_select;
  logic                        cfg_gate;
  clk_domain_pkg::domain_vec_t free_en;
  clk_domain_pkg::domain_vec_t gated_en;
  int                          errors;

  periph_clk_enable_ctrl UUT (
    .master_clk (master_clk),
    .rst        (rst),
    .cfg_valid  (cfg_valid),
    .cfg_ready  (cfg_ready),
    .cfg_domain (cfg_domain),
    .cfg_select (cfg_select),
    .cfg_gate   (cfg_gate),
    .free_en    (free_en),
    .gated_en   (gated_en)
  );

  always #(CLK_PERIOD / 2) master_clk = ~master_clk;

  // ------------------------------
  // Helpers
  // ------------------------------

  // Pulse spacing of a select code
  // Codes above 5 run at divide by 32
  function automatic int expected_gap(input int sel);
    int k;
    k = (sel > 5) ? 5 : sel;
    return 1 << k;
  endfunction

  task automatic report_value(input string name, input int got, input int exp);
    $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_latency(input string what, input int lat);
    $display("Apply latency out of range at %0t: %s took %0d cycles instead of 1 to 32",
             $time, what, lat);
    errors++;
  endtask

  // Counts falling edges with cfg_ready low
  task automatic wait_ready(output int low_cycles);
    low_cycles = 0;
    while (cfg_ready !== 1'b1 && low_cycles < STALL_LIMIT) begin
      @(negedge master_clk);
      low_cycles++;
    end
    if (cfg_ready !== 1'b1) begin
      $display("Config port stalled: cfg_ready low for %0d cycles at %0t", STALL_LIMIT, $time);
      errors++;
    end
  endtask

  task automatic cfg_write(input clk_domain_pkg::domain_id_t dom,
                           input clk_ratio_pkg::ratio_sel_t sel,
                           input logic gate, output int latency);
    int idle;
    repeat ($urandom_range(0, 3)) @(negedge master_clk);
    cfg_domain = dom;
    cfg_select = sel;
    cfg_gate   = gate;
    cfg_valid  = 1'b1;
    wait_ready(idle);
    // Transfer happens on the next rising edge
    @(negedge master_clk);
    cfg_valid = 1'b0;
    wait_ready(latency);
  endtask

  task automatic measure_spacing(input clk_domain_pkg::domain_id_t dom, input int gap,
                                 input int pulses);
    int cycle;
    int last;
    int seen;
    int limit;
    last  = -1;
    seen  = 0;
    cycle = 0;
    limit = (pulses + 1) * gap + 2;
    while (seen < pulses && cycle < limit) begin
      @(negedge master_clk);
      cycle++;
      if (free_en[dom]) begin
        if (last >= 0 && cycle - last != gap) begin
          report_value($sformatf("free_en[%0d] gap", dom), cycle - last, gap);
        end
        last = cycle;
        seen++;
      end
    end
    if (seen < pulses) begin
      $display("Missing pulses: free_en[%0d] pulsed %0d of %0d times", dom, seen, pulses);
      errors++;
    end
  endtask

  // A gated domain holds gated_en low while every other domain follows free_en
  task automatic check_gating(input clk_domain_pkg::domain_vec_t gate_mask, input int cycles);
    clk_domain_pkg::domain_id_t idx;
    logic exp;
    int   pulses;
    pulses = 0;
    repeat (cycles) begin
      @(negedge master_clk);
      for (int d = 0; d < clk_domain_pkg::N_DOMAINS; d++) begin
        idx = clk_domain_pkg::domain_id_t'(d);
        exp = gate_mask[idx] ? 1'b0 : free_en[idx];
        if (gated_en[idx] !== exp) begin
          report_value($sformatf("gated_en[%0d]", d), int'(gated_en[idx]), int'(exp));
        end
        if (gate_mask[idx] && free_en[idx]) pulses++;
      end
    end
    if (gate_mask != '0 && pulses == 0) begin
      $display("Gated domain lost its free enable pulses at %0t", $time);
      errors++;
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------

  task automatic test_reset();
    rst = 1'b1;
    repeat (RESET_CYCLES) begin
      @(negedge master_clk);
      if (free_en !== '0) report_value("free_en", int'(free_en), 0);
      if (gated_en !== '0) report_value("gated_en", int'(gated_en), 0);
      if (cfg_ready !== 1'b1) report_value("cfg_ready", int'(cfg_ready), 1);
    end
    rst = 1'b0;
    // Divide by 1 default enables every domain on every cycle
    repeat (40) begin
      @(negedge master_clk);
      if (free_en !== '1) report_value("free_en", int'(free_en), 31);
      if (gated_en !== '1) report_value("gated_en", int'(gated_en), 31);
      if (cfg_ready !== 1'b1) report_value("cfg_ready", int'(cfg_ready), 1);
    end
  endtask

  task automatic test_spacing();
    int lat;
    int t1_sel;
    t1_sel = int'($urandom_range(0, 7));
    cfg_write(clk_domain_pkg::DOM_TIMER1, clk_ratio_pkg::ratio_sel_t'(t1_sel), 1'b0, lat);
    for (int s = 0; s < 8; s++) begin
      cfg_write(clk_domain_pkg::DOM_UART0, clk_ratio_pkg::ratio_sel_t'(s), 1'b0, lat);
      measure_spacing(clk_domain_pkg::DOM_UART0, expected_gap(s), 4);
      measure_spacing(clk_domain_pkg::DOM_TIMER1, expected_gap(t1_sel), 3);
    end
  endtask

  task automatic test_gating();
    int lat;
    cfg_write(clk_domain_pkg::DOM_TIMER0, 3'd1, 1'b1, lat);
    check_gating(5'b00001, GATE_WATCH);
    cfg_write(clk_domain_pkg::DOM_TIMER0, 3'd1, 1'b0, lat);
    check_gating(5'b00000, GATE_WATCH);
  endtask

  task automatic test_backpressure();
    int lat;
    cfg_write(clk_domain_pkg::DOM_UART1, 3'd2, 1'b0, lat);
    repeat ($urandom_range(0, 31)) @(negedge master_clk);
    cfg_domain = clk_domain_pkg::DOM_UART1;
    cfg_select = 3'd5;
    cfg_gate   = 1'b0;
    cfg_valid  = 1'b1;
    @(negedge master_clk);
    if (cfg_ready !== 1'b0) report_value("cfg_ready", int'(cfg_ready), 0);
    // Second write waits behind the first
    cfg_select = 3'd3;
    wait_ready(lat);
    if (lat < 1 || lat > 32) report_latency("first write", lat);
    @(negedge master_clk);
    cfg_valid = 1'b0;
    lat = 0;
    // Divide by 32 from the first write gives no pulse before the next boundary
    while (cfg_ready !== 1'b1 && lat < STALL_LIMIT) begin
      if (free_en[clk_domain_pkg::DOM_UART1] !== 1'b0) begin
        report_value("free_en[3]", int'(free_en[clk_domain_pkg::DOM_UART1]), 0);
      end
      @(negedge master_clk);
      lat++;
    end
    if (lat < 1 || lat > 32) report_latency("second write", lat);
    measure_spacing(clk_domain_pkg::DOM_UART1, 8, 4);
  endtask

  task automatic test_alignment();
    int lat;
    int hits;
    for (int d = 0; d < clk_domain_pkg::N_DOMAINS; d++) begin
      cfg_write(clk_domain_pkg::domain_id_t'(d), clk_ratio_pkg::ratio_sel_t'(d + 1), 1'b0, lat);
    end
    hits = 0;
    repeat (ALIGN_WATCH) begin
      @(negedge master_clk);
      if (free_en[clk_domain_pkg::DOM_WDOG]) begin
        hits++;
        if (free_en !== '1) report_value("free_en", int'(free_en), 31);
      end
    end
    if (hits < 3) begin
      $display("Watchdog enable pulsed only %0d times in %0d cycles", hits, ALIGN_WATCH);
      errors++;
    end
  endtask

  task automatic test_invalid_domain();
    int lat;
    for (int d = 5; d < 8; d++) begin
      cfg_write(clk_domain_pkg::domain_id_t'(d),
                clk_ratio_pkg::ratio_sel_t'($urandom_range(0, 7)), 1'b1, lat);
      if (lat < 1 || lat > 32) report_latency($sformatf("write to domain %0d", d), lat);
    end
    for (int d = 0; d < clk_domain_pkg::N_DOMAINS; d++) begin
      measure_spacing(clk_domain_pkg::domain_id_t'(d), expected_gap(d + 1), 3);
    end
    check_gating(5'b00000, GATE_WATCH);
  endtask

  // ------------------------------
  // Run control
  // ------------------------------

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests still running after %0d cycles", 2 * TOTAL_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    master_clk = 1'b0;
    rst        = 1'b1;
    cfg_valid  = 1'b0;
    cfg_domain = '0;
    cfg_select = '0;
    cfg_gate   = 1'b0;
    errors     = 0;
    void'($urandom(32'h5842125c));

    test_reset();
    test_spacing();
    test_gating();
    test_backpressure();
    test_alignment();
    test_invalid_domain();

    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: verilog.f
hw/clk_ratio_pkg.sv
hw/clk_domain_pkg.sv
hw/ratio_strobe_gen.sv
hw/domain_config.sv
hw/domain_enable_mux.sv
hw/periph_clk_enable_ctrl.sv
dv/periph_clk_enable_ctrl_tb.sv

// File: Makefile
# Verilator build and run for the peripheral clock-enable controller

VERILATOR ?= verilator
TOP       ?= periph_clk_enable_ctrl_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
FAIL_MSG  ?= ERRORS FOUND
PASS_MSG  ?= NO ERRORS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
